//--- include/lb_defines.svh
// Local bus demo slave shared sizes
// Bus widths, storage depths and fixed read words
`ifndef LB_DEFINES_SVH
`define LB_DEFINES_SVH

// Bus widths
`define LB_ADDR_W       24
`define LB_DATA_W       32

// Storage and counter widths
`define LB_MIRROR_AW    5
`define LB_CNT_W        20
`define LB_CAT_W        4
`define LB_FAULT_W      16
`define LB_DUTY_W       8
`define LB_PWM_W        10

// Fixed read words
`define LB_NOMAP_WORD   32'hdeadbeef
`define LB_UNUSED_WORD  "zzzz"
`define LB_HELLO_0      "Hell"
`define LB_HELLO_1      "o wo"
`define LB_HELLO_2      "rld!"
`define LB_HELLO_3      "(::)"

`endif

//--- hdl/lb_pkg.sv
// Local bus demo slave types
// Region codes and the records passed between pipeline stages
`include "lb_defines.svh"

package lb_pkg;

	// Decoded target of one access
	typedef enum logic [1:0] {
		REGION_MIRROR   = 2'd0,
		REGION_COUNTERS = 2'd1,
		REGION_STATUS   = 2'd2,
		REGION_NONE     = 2'd3
	} lb_region_e;

	// Decode to execute
	typedef struct packed {
		logic                     rd;
		logic                     wr;
		lb_region_e               region;
		logic [`LB_MIRROR_AW-1:0] index;
		logic [`LB_DATA_W-1:0]    wdata;
	} lb_req_t;

	// Execute to result
	typedef struct packed {
		logic                  rd;
		lb_region_e            region;
		logic [`LB_DATA_W-1:0] status_word;
		logic [`LB_DATA_W-1:0] mirror_word;
		logic [`LB_CNT_W-1:0]  counter_word;
	} lb_exec_t;

	// Control registers seen by the LEDs and the outputs
	typedef struct packed {
		logic                  led_user;
		logic [`LB_DUTY_W-1:0] led1_duty;
		logic [`LB_DUTY_W-1:0] led2_duty;
		logic [`LB_DATA_W-1:0] scratch;
	} lb_ctrl_t;

endpackage

//--- hdl/lb_decode.sv
// Local bus decode stage
// Samples the strobe and classifies the address into a region,
// a word index and a read or write request
`timescale 1ns/1ps
`include "lb_defines.svh"

module lb_decode (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   strobe,
	input  logic                   rd,
	input  logic [`LB_ADDR_W-1:0]  addr,
	input  logic [`LB_DATA_W-1:0]  wdata,
	output lb_pkg::lb_req_t        req
);
	import lb_pkg::*;

	// Page select is the top address byte
	logic [7:0]               page;
	lb_region_e               region_d;
	logic                     rd_d;
	logic                     wr_d;

	// Request registers
	logic                     rd_q;
	logic                     wr_q;
	lb_region_e               region_q;
	logic [`LB_MIRROR_AW-1:0] index_q;
	logic [`LB_DATA_W-1:0]    wdata_q;

	assign page = addr[`LB_ADDR_W-1:`LB_ADDR_W-8];

	// ================================================
	// Address classification
	// ================================================
	always_comb begin
		case (page)
			8'h00: region_d = REGION_MIRROR;
			// Counter bank only in the 0x041xxx window
			8'h04: region_d = (addr[15:12] == 4'h1) ? REGION_COUNTERS : REGION_NONE;
			8'h11: region_d = REGION_STATUS;
			default: region_d = REGION_NONE;
		endcase
	end

	assign rd_d = strobe & rd;
	// Only page 0 is writable, other writes vanish here
	assign wr_d = strobe & ~rd & (region_d == REGION_MIRROR);

	// Control bits
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
		end else begin
			rd_q <= rd_d;
			wr_q <= wr_d;
		end
	end

	// Payload, only meaningful alongside rd_q or wr_q
	always_ff @(posedge clk) begin
		region_q <= region_d;
		index_q  <= addr[`LB_MIRROR_AW-1:0];
		wdata_q  <= wdata;
	end

	assign req.rd     = rd_q;
	assign req.wr     = wr_q;
	assign req.region = region_q;
	assign req.index  = index_q;
	assign req.wdata  = wdata_q;

	// A strobe must carry a defined direction and address
	a_strobe_known: assert property (
		@(posedge clk) disable iff (!arst_n) strobe |-> !$isunknown({rd, addr})
	) else $error("strobe with unknown read level or address");

endmodule

//--- hdl/lb_event_counter.sv
// Event counter bank
// Sixteen wrapping counters, one increment port and one
// registered read port
`timescale 1ns/1ps
`include "lb_defines.svh"

module lb_event_counter (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 inc,
	input  logic [`LB_CAT_W-1:0] inc_index,
	input  logic [`LB_CAT_W-1:0] read_index,
	output logic [`LB_CNT_W-1:0] count
);

	// One counter per category
	logic [`LB_CNT_W-1:0] cnt_mem [2**`LB_CAT_W];

	// ================================================
	// Increment side
	// ================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**`LB_CAT_W; i++) begin
				cnt_mem[i] <= '0;
			end
		end else if (inc) begin
			// Wraps at 2**20
			cnt_mem[inc_index] <= cnt_mem[inc_index] + `LB_CNT_W'(1);
		end
	end

	// ================================================
	// Read side
	// ================================================
	// Registered every cycle, an increment in the same cycle
	// shows up on the next read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else begin
			count <= cnt_mem[read_index];
		end
	end

endmodule

//--- hdl/lb_execute.sv
// Local bus execute stage
// Mirror RAM, control registers, status bank and housekeeping
// counters; registers all read sources one cycle after decode
`timescale 1ns/1ps
`include "lb_defines.svh"

module lb_execute (
	input  logic                  clk,
	input  logic                  arst_n,
	input  lb_pkg::lb_req_t       req,
	input  logic                  xdomain_fault,
	input  logic                  rx_category_s,
	input  logic [`LB_CAT_W-1:0]  rx_category,
	input  logic [`LB_DATA_W-1:0] scratch_in,
	input  logic                  tick,
	output lb_pkg::lb_exec_t      exe,
	output lb_pkg::lb_ctrl_t      ctrl
);
	import lb_pkg::*;

	// Mirror storage, no reset
	logic [`LB_DATA_W-1:0]  mirror_mem [2**`LB_MIRROR_AW];

	// Housekeeping state
	logic [`LB_FAULT_W-1:0] fault_cnt;
	logic [`LB_DATA_W-1:0]  uptime;
	logic [`LB_DATA_W-1:0]  scratch_in_q;
	lb_ctrl_t               ctrl_q;

	// Read side registers
	logic                   rd_q;
	lb_region_e             region_q;
	logic [`LB_DATA_W-1:0]  status_d;
	logic [`LB_DATA_W-1:0]  status_q;
	logic [`LB_DATA_W-1:0]  mirror_q;
	logic [`LB_CNT_W-1:0]   counter_word;

	// ================================================
	// Housekeeping counters
	// ================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fault_cnt    <= '0;
			uptime       <= '0;
			scratch_in_q <= '0;
		end else begin
			// Wraps silently
			if (xdomain_fault)
				fault_cnt <= fault_cnt + `LB_FAULT_W'(1);
			// One step per PWM period
			if (tick)
				uptime <= uptime + `LB_DATA_W'(1);
			scratch_in_q <= scratch_in;
		end
	end

	// Per-category receive statistics
	lb_event_counter event_counter_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.inc        (rx_category_s),
		.inc_index  (rx_category),
		.read_index (req.index[`LB_CAT_W-1:0]),
		.count      (counter_word)
	);

	// ================================================
	// Page 0 writes
	// ================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_q <= '0;
		end else if (req.wr) begin
			case (req.index)
				5'd1: ctrl_q.led_user  <= req.wdata[0];
				5'd2: ctrl_q.led1_duty <= req.wdata[`LB_DUTY_W-1:0];
				5'd3: ctrl_q.led2_duty <= req.wdata[`LB_DUTY_W-1:0];
				5'd7: ctrl_q.scratch   <= req.wdata;
				default: ;
			endcase
		end
	end

	// Mirror write and read share one index
	always_ff @(posedge clk) begin
		if (req.wr)
			mirror_mem[req.index] <= req.wdata;
		if (req.rd)
			mirror_q <= mirror_mem[req.index];
	end

	// ================================================
	// Status bank
	// ================================================
	always_comb begin
		case (req.index)
			5'd0: status_d = `LB_HELLO_0;
			5'd1: status_d = `LB_HELLO_1;
			5'd2: status_d = `LB_HELLO_2;
			5'd3: status_d = `LB_HELLO_3;
			5'd4: status_d = {{(`LB_DATA_W-`LB_FAULT_W){1'b0}}, fault_cnt};
			5'd5: status_d = uptime;
			5'd6: status_d = scratch_in_q;
			default: status_d = `LB_UNUSED_WORD;
		endcase
	end

	always_ff @(posedge clk) begin
		if (req.rd)
			status_q <= status_d;
	end

	// Read request travels with its data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_q     <= 1'b0;
			region_q <= REGION_NONE;
		end else begin
			rd_q     <= req.rd;
			region_q <= req.region;
		end
	end

	assign exe.rd           = rd_q;
	assign exe.region       = region_q;
	assign exe.status_word  = status_q;
	assign exe.mirror_word  = mirror_q;
	assign exe.counter_word = counter_word;

	assign ctrl = ctrl_q;

	// Writes only ever reach the mirror page
	a_wr_mirror_only: assert property (
		@(posedge clk) disable iff (!arst_n) req.wr |-> req.region == REGION_MIRROR
	) else $error("write request outside the mirror region");

endmodule

//--- hdl/lb_led_pwm.sv
// LED PWM generator
// Free-running period counter, two duty compares and a
// one-cycle tick per period for the uptime counter
`timescale 1ns/1ps
`include "lb_defines.svh"

module lb_led_pwm (
	input  logic             clk,
	input  logic             arst_n,
	input  lb_pkg::lb_ctrl_t ctrl,
	output logic             led1,
	output logic             led2,
	output logic             tick
);

	// Period counter, 1024 cycles per period
	logic [`LB_PWM_W-1:0] pwm_cnt;

	// Duty scaled to the counter width
	logic [`LB_PWM_W-1:0] thresh1;
	logic [`LB_PWM_W-1:0] thresh2;

	// Four counts per duty step
	assign thresh1 = {ctrl.led1_duty, 2'b00};
	assign thresh2 = {ctrl.led2_duty, 2'b00};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pwm_cnt <= '0;
			tick    <= 1'b0;
			led1    <= 1'b0;
			led2    <= 1'b0;
		end else begin
			pwm_cnt <= pwm_cnt + `LB_PWM_W'(1);
			// Wrap marker
			tick    <= &pwm_cnt;
			// Duty 0 never passes the compare
			led1    <= pwm_cnt < thresh1;
			led2    <= pwm_cnt < thresh2;
		end
	end

endmodule

//--- hdl/lb_read_result.sv
// Local bus result stage
// Picks the read word by region and returns it with a
// one-cycle rd_valid pulse
`timescale 1ns/1ps
`include "lb_defines.svh"

module lb_read_result (
	input  logic                  clk,
	input  logic                  arst_n,
	input  lb_pkg::lb_exec_t      exe,
	output logic [`LB_DATA_W-1:0] rdata,
	output logic                  rd_valid
);
	import lb_pkg::*;

	logic [`LB_DATA_W-1:0] sel_word;

	// ================================================
	// Region select
	// ================================================
	always_comb begin
		case (exe.region)
			REGION_MIRROR:   sel_word = exe.mirror_word;
			// Counters are narrower than the bus
			REGION_COUNTERS: sel_word = {{(`LB_DATA_W-`LB_CNT_W){1'b0}}, exe.counter_word};
			REGION_STATUS:   sel_word = exe.status_word;
			default:         sel_word = `LB_NOMAP_WORD;
		endcase
	end

	// Data held between reads
	always_ff @(posedge clk) begin
		if (exe.rd)
			rdata <= sel_word;
	end

	// One valid per read, no back-pressure
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= exe.rd;
		end
	end

	// Whole pipeline must deliver defined data
	a_rdata_known: assert property (
		@(posedge clk) disable iff (!arst_n) rd_valid |-> !$isunknown(rdata)
	) else $error("read data has unknown bits");

endmodule

//--- hdl/lb_demo_top.sv
// Local bus demo slave
// Three-stage read pipeline with mirror RAM, status bank,
// event counters and two PWM LEDs
`timescale 1ns/1ps
`include "lb_defines.svh"

module lb_demo_top (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  strobe,
	input  logic                  rd,
	input  logic [`LB_ADDR_W-1:0] addr,
	input  logic [`LB_DATA_W-1:0] wdata,
	input  logic                  xdomain_fault,
	input  logic                  rx_category_s,
	input  logic [`LB_CAT_W-1:0]  rx_category,
	input  logic [`LB_DATA_W-1:0] scratch_in,
	output logic [`LB_DATA_W-1:0] rdata,
	output logic                  rd_valid,
	output logic                  led_user_mode,
	output logic                  led1,
	output logic                  led2,
	output logic [`LB_DATA_W-1:0] scratch_out
);
	import lb_pkg::*;

	// Stage links
	lb_req_t  req;
	lb_exec_t exe;
	lb_ctrl_t ctrl;
	logic     tick;

	// ================================================
	// Pipeline
	// ================================================
	lb_decode decode_i (
		.clk    (clk),
		.arst_n (arst_n),
		.strobe (strobe),
		.rd     (rd),
		.addr   (addr),
		.wdata  (wdata),
		.req    (req)
	);

	lb_execute execute_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.req           (req),
		.xdomain_fault (xdomain_fault),
		.rx_category_s (rx_category_s),
		.rx_category   (rx_category),
		.scratch_in    (scratch_in),
		.tick          (tick),
		.exe           (exe),
		.ctrl          (ctrl)
	);

	lb_read_result result_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.exe      (exe),
		.rdata    (rdata),
		.rd_valid (rd_valid)
	);

	// LEDs and uptime tick
	lb_led_pwm pwm_i (
		.clk    (clk),
		.arst_n (arst_n),
		.ctrl   (ctrl),
		.led1   (led1),
		.led2   (led2),
		.tick   (tick)
	);

	assign led_user_mode = ctrl.led_user;
	assign scratch_out   = ctrl.scratch;

endmodule

//--- dv/lb_demo_tb.sv
// Local bus demo slave testbench
// Directed tests of the address map, mirror RAM, control registers,
// event counters and PWM timing
`timescale 1ns/1ps
`include "lb_defines.svh"

module lb_demo_tb;
	import lb_pkg::*;

	// Tests need under 10k cycles
	localparam int WATCHDOG_CYCLES = 20000;

	logic                  clk = 1'b0;
	logic                  arst_n;
	logic                  strobe;
	logic                  rd;
	logic [`LB_ADDR_W-1:0] addr;
	logic [`LB_DATA_W-1:0] wdata;
	logic                  xdomain_fault;
	logic                  rx_category_s;
	logic [`LB_CAT_W-1:0]  rx_category;
	logic [`LB_DATA_W-1:0] scratch_in;
	logic [`LB_DATA_W-1:0] rdata;
	logic                  rd_valid;
	logic                  led_user_mode;
	logic                  led1;
	logic                  led2;
	logic [`LB_DATA_W-1:0] scratch_out;

	// Reference state built from the writes
	logic [`LB_DATA_W-1:0] mirror_model [2**`LB_MIRROR_AW];
	lb_ctrl_t              ctrl_model;

	always #4 clk = ~clk;

	lb_demo_top dut_i (.*);

	task automatic stop_run();
		$display("Verification failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [`LB_DATA_W-1:0] exp,
			input logic [`LB_DATA_W-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_ctrl(input string name, input lb_ctrl_t exp, input lb_ctrl_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic bus_write(input logic [`LB_ADDR_W-1:0] waddr,
			input logic [`LB_DATA_W-1:0] wword);
		strobe = 1'b1;
		rd     = 1'b0;
		addr   = waddr;
		wdata  = wword;
		next_cycle();
		strobe = 1'b0;
		// Page 0 writes also land in the control registers
		if (waddr[23:16] == 8'h00) begin
			mirror_model[waddr[4:0]] = wword;
			case (waddr[4:0])
				5'd1: ctrl_model.led_user  = wword[0];
				5'd2: ctrl_model.led1_duty = wword[7:0];
				5'd3: ctrl_model.led2_duty = wword[7:0];
				5'd7: ctrl_model.scratch   = wword;
				default: ;
			endcase
		end
	endtask

	// rd_valid low one cycle after sampling and high the next
	task automatic bus_read(input string name, input logic [`LB_ADDR_W-1:0] raddr,
			output logic [`LB_DATA_W-1:0] data);
		strobe = 1'b1;
		rd     = 1'b1;
		addr   = raddr;
		next_cycle();
		strobe = 1'b0;
		next_cycle();
		check_bit({name, " early rd_valid"}, 1'b0, rd_valid);
		next_cycle();
		check_bit({name, " rd_valid"}, 1'b1, rd_valid);
		data = rdata;
	endtask

	task automatic read_expect(input string name, input logic [`LB_ADDR_W-1:0] raddr,
			input logic [`LB_DATA_W-1:0] exp);
		logic [`LB_DATA_W-1:0] got;
		bus_read(name, raddr, got);
		check_word(name, exp, got);
	endtask

	// ==================================================
	// Directed tests
	// ==================================================
	task automatic test_reset_status();
		check_bit("reset rd_valid", 1'b0, rd_valid);
		check_bit("reset led1", 1'b0, led1);
		check_bit("reset led2", 1'b0, led2);
		check_bit("reset led_user_mode", 1'b0, led_user_mode);
		check_word("reset scratch_out", '0, scratch_out);
		read_expect("reset fault count", 24'h110004, '0);
		read_expect("reset uptime", 24'h110005, '0);
		read_expect("status hello 0", 24'h110000, "Hell");
		read_expect("status hello 1", 24'h110001, "o wo");
		read_expect("status hello 2", 24'h110002, "rld!");
		read_expect("status hello 3", 24'h110003, "(::)");
		read_expect("status scratch_in", 24'h110006, scratch_in);
		for (int i = 7; i < 16; i++)
			read_expect("status unused", 24'h110000 + 24'(i), `LB_UNUSED_WORD);
		read_expect("unmapped page", 24'h200000, `LB_NOMAP_WORD);
	endtask

	task automatic test_mirror_ctrl();
		for (int i = 0; i < 32; i++)
			bus_write(24'(i), $urandom);
		// Back-to-back reads, each answer three drive slots after its strobe
		for (int j = 0; j < 36; j++) begin
			if (j >= 3 && j < 35)
				check_word("mirror readback", mirror_model[5'(j - 3)], rdata);
			check_bit("mirror rd_valid", j >= 3 && j < 35, rd_valid);
			strobe = (j < 32);
			rd     = 1'b1;
			addr   = 24'(j);
			next_cycle();
		end
		bus_write(24'h000001, 32'h1);
		bus_write(24'h000002, 32'($urandom_range(255, 1)));
		bus_write(24'h000003, 32'h5a);
		bus_write(24'h000007, $urandom);
		next_cycle();
		check_ctrl("ctrl after writes", ctrl_model, dut_i.ctrl);
		check_bit("led_user_mode", ctrl_model.led_user, led_user_mode);
		check_word("scratch_out", ctrl_model.scratch, scratch_out);
		// Status page is read only
		bus_write(24'h110001, ~mirror_model[1]);
		next_cycle();
		check_ctrl("ctrl after status write", ctrl_model, dut_i.ctrl);
		read_expect("mirror after status write", 24'h000001, mirror_model[1]);
	endtask

	task automatic test_counters();
		int cnt_model [16];
		int n;
		for (int c = 0; c < 16; c++) begin
			cnt_model[4'(c)] = $urandom_range(6, 0);
			rx_category = 4'(c);
			repeat (cnt_model[4'(c)]) begin
				rx_category_s = 1'b1;
				next_cycle();
			end
			rx_category_s = 1'b0;
		end
		for (int c = 0; c < 16; c++)
			read_expect("event counter", 24'h041000 + 24'(c), cnt_model[4'(c)]);
		n = $urandom_range(20, 1);
		repeat (n) begin
			xdomain_fault = 1'b1;
			next_cycle();
		end
		xdomain_fault = 1'b0;
		read_expect("fault count", 24'h110004, n);
	endtask

	task automatic test_pwm_uptime();
		logic [7:0]            duty;
		int                    high;
		int                    led2_high;
		logic [`LB_DATA_W-1:0] up0;
		logic [`LB_DATA_W-1:0] up1;
		duty = 8'($urandom_range(255, 1));
		// Random duty first, then duty 0
		for (int pass = 0; pass < 2; pass++) begin
			bus_write(24'h000002, {24'h0, duty});
			repeat (4) next_cycle();
			high      = 0;
			led2_high = 0;
			repeat (1024) begin
				if (led1)
					high++;
				if (led2)
					led2_high++;
				next_cycle();
			end
			check_word("led1 high cycles", 32'(4 * int'(duty)), high);
			// led2 keeps the duty written earlier
			check_word("led2 high cycles", 32'(4 * int'(ctrl_model.led2_duty)), led2_high);
			duty = 8'h00;
		end
		// Second strobe sampled 4096 edges after the first
		bus_read("uptime first", 24'h110005, up0);
		repeat (4093) next_cycle();
		bus_read("uptime second", 24'h110005, up1);
		check_word("uptime step", up0 + 32'd4, up1);
	endtask

	initial begin
		void'($urandom(32'h1976_5c69));
		arst_n        = 1'b0;
		strobe        = 1'b0;
		rd            = 1'b0;
		addr          = '0;
		wdata         = '0;
		xdomain_fault = 1'b0;
		rx_category_s = 1'b0;
		rx_category   = '0;
		scratch_in    = $urandom;
		ctrl_model    = '0;
		repeat (2) @(posedge clk);
		#1 arst_n = 1'b1;
		next_cycle();
		test_reset_status();
		test_mirror_ctrl();
		test_counters();
		test_pwm_uptime();
		$display("Verification passed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("Verification failed");
		$fatal(1, "timeout");
	end

endmodule

//--- compile.f
+incdir+include
hdl/lb_pkg.sv
hdl/lb_decode.sv
hdl/lb_event_counter.sv
hdl/lb_execute.sv
hdl/lb_led_pwm.sv
hdl/lb_read_result.sv
hdl/lb_demo_top.sv
dv/lb_demo_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= compile.f
TB_TOP    ?= lb_demo_tb
RTL_TOP   ?= lb_demo_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(TB_TOP)
	@out="$$(./$(OBJ_DIR)/$(TB_TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
